//--- Bender.yml
package:
  name: axi_sram_bridge

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/axi_types_pkg.sv
      - common/sram_types_pkg.sv
      - common/sram_cmd_if.sv
      - sram_bridge/burst_counter.sv
      - sram_bridge/axi_wr_path.sv
      - sram_bridge/axi_rd_path.sv
      - sram_bridge/sram_arbiter.sv
      - hw/sram_array.sv
      - hw/axi_sram_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/axi_sram_tb.sv

//--- common/axi_sram_params.svh
`ifndef AXI_SRAM_PARAMS_SVH
`define AXI_SRAM_PARAMS_SVH

// AXI side
`define AXI_ADDR_W 20
`define AXI_DATA_W 16
`define AXI_ID_W   4

// SRAM geometry, in words
`define SRAM_DEPTH 1024

// Word address bits needed to index SRAM_DEPTH words
`define SRAM_ADDR_W 10

// One strobe bit per data byte
`define STRB_W (`AXI_DATA_W / 8)

// Byte offset bits dropped from an AXI address
`define BYTE_LSB 1

`endif

//--- common/axi_types_pkg.sv
`include "axi_sram_params.svh"

package axi_types_pkg;

  // Transaction ID as seen on AW, B, AR and R
  typedef logic [`AXI_ID_W-1:0] axi_id_t;

  // Byte address
  typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;

  // Number of beats minus one
  typedef logic [7:0] axi_len_t;

  // BRESP and RRESP
  typedef logic [1:0] axi_resp_t;

  // Only response the bridge ever returns
  localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

endpackage

//--- common/sram_cmd_if.sv
interface sram_cmd_if;
  import sram_types_pkg::*;

  logic       valid;
  logic       ready;
  logic       wr_en;
  sram_addr_t addr;
  sram_meta_t meta;
  sram_data_t wr_data;
  sram_strb_t wr_strb;

  modport requester (
    output valid,
    output wr_en,
    output addr,
    output meta,
    output wr_data,
    output wr_strb,
    input  ready
  );

  modport server (
    input  valid,
    input  wr_en,
    input  addr,
    input  meta,
    input  wr_data,
    input  wr_strb,
    output ready
  );

endinterface

//--- common/sram_types_pkg.sv
`include "axi_sram_params.svh"

package sram_types_pkg;

  // Word address into the SRAM
  typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;

  typedef logic [`AXI_DATA_W-1:0] sram_data_t;

  // Byte enables for one word
  typedef logic [`STRB_W-1:0] sram_strb_t;

  // Read tag, {ID, last beat}
  typedef logic [`AXI_ID_W:0] sram_meta_t;

  // Grant states of the SRAM arbiter
  typedef enum logic [2:0] {
    ARB_IDLE,
    ARB_READ,
    ARB_READ_RESP,
    ARB_WRITE,
    ARB_WRITE_RESP
  } arb_state_t;

endpackage

//--- flist.f
+incdir+common
common/axi_types_pkg.sv
common/sram_types_pkg.sv
common/sram_cmd_if.sv
sram_bridge/burst_counter.sv
sram_bridge/axi_wr_path.sv
sram_bridge/axi_rd_path.sv
sram_bridge/sram_arbiter.sv
hw/sram_array.sv
hw/axi_sram_top.sv
sim/axi_sram_tb.sv

//--- hw/axi_sram_top.sv
module axi_sram_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       i_awvalid,
  output logic                       o_awready,
  input  axi_types_pkg::axi_id_t     i_awid,
  input  axi_types_pkg::axi_addr_t   i_awaddr,
  input  axi_types_pkg::axi_len_t    i_awlen,
  input  logic [2:0]                 i_awsize,
  input  logic [1:0]                 i_awburst,
  input  logic                       i_wvalid,
  output logic                       o_wready,
  input  sram_types_pkg::sram_data_t i_wdata,
  input  sram_types_pkg::sram_strb_t i_wstrb,
  input  logic                       i_wlast,
  output logic                       o_bvalid,
  input  logic                       i_bready,
  output axi_types_pkg::axi_id_t     o_bid,
  output axi_types_pkg::axi_resp_t   o_bresp,
  input  logic                       i_arvalid,
  output logic                       o_arready,
  input  axi_types_pkg::axi_id_t     i_arid,
  input  axi_types_pkg::axi_addr_t   i_araddr,
  input  axi_types_pkg::axi_len_t    i_arlen,
  input  logic [2:0]                 i_arsize,
  input  logic [1:0]                 i_arburst,
  output logic                       o_rvalid,
  input  logic                       i_rready,
  output axi_types_pkg::axi_id_t     o_rid,
  output sram_types_pkg::sram_data_t o_rdata,
  output axi_types_pkg::axi_resp_t   o_rresp,
  output logic                       o_rlast
);
  import sram_types_pkg::*;

  logic       resp_valid;
  logic       resp_ready;
  sram_data_t resp_data;
  sram_meta_t resp_meta;

  sram_cmd_if wr_req ();
  sram_cmd_if rd_req ();
  sram_cmd_if mem_cmd ();

  axi_wr_path i_axi_wr_path (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_awvalid(i_awvalid),
    .o_awready(o_awready),
    .i_awid   (i_awid),
    .i_awaddr (i_awaddr),
    .i_awlen  (i_awlen),
    .i_awsize (i_awsize),
    .i_awburst(i_awburst),
    .i_wvalid (i_wvalid),
    .o_wready (o_wready),
    .i_wdata  (i_wdata),
    .i_wstrb  (i_wstrb),
    .i_wlast  (i_wlast),
    .o_bvalid (o_bvalid),
    .i_bready (i_bready),
    .o_bid    (o_bid),
    .o_bresp  (o_bresp),
    .wr_req   (wr_req.requester)
  );

  axi_rd_path i_axi_rd_path (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_arvalid   (i_arvalid),
    .o_arready   (o_arready),
    .i_arid      (i_arid),
    .i_araddr    (i_araddr),
    .i_arlen     (i_arlen),
    .i_arsize    (i_arsize),
    .i_arburst   (i_arburst),
    .o_rvalid    (o_rvalid),
    .i_rready    (i_rready),
    .o_rid       (o_rid),
    .o_rdata     (o_rdata),
    .o_rresp     (o_rresp),
    .o_rlast     (o_rlast),
    .rd_req      (rd_req.requester),
    .i_resp_valid(resp_valid),
    .o_resp_ready(resp_ready),
    .i_resp_data (resp_data),
    .i_resp_meta (resp_meta)
  );

  sram_arbiter i_sram_arbiter (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_req  (wr_req.server),
    .rd_req  (rd_req.server),
    .mem_cmd (mem_cmd.requester),
    .i_rready(i_rready),
    .i_bready(i_bready)
  );

  sram_array i_sram_array (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (mem_cmd.server),
    .o_resp_valid(resp_valid),
    .i_resp_ready(resp_ready),
    .o_resp_data (resp_data),
    .o_resp_meta (resp_meta)
  );

endmodule

//--- hw/sram_array.sv
`include "axi_sram_params.svh"

module sram_array (
  input  logic                       clk,
  input  logic                       rst_n,
  sram_cmd_if.server                 cmd,
  output logic                       o_resp_valid,
  input  logic                       i_resp_ready,
  output sram_types_pkg::sram_data_t o_resp_data,
  output sram_types_pkg::sram_meta_t o_resp_meta
);
  import sram_types_pkg::*;

  sram_data_t mem [`SRAM_DEPTH];
  logic       accept;
  logic       rd_accept;

  // Free when the response register is empty or draining now
  assign cmd.ready = !o_resp_valid || i_resp_ready;
  assign accept    = cmd.valid && cmd.ready;
  assign rd_accept = accept && !cmd.wr_en;

  always_ff @(posedge clk) begin
    if (accept && cmd.wr_en) begin
      for (int b = 0; b < `STRB_W; b++) begin
        if (cmd.wr_strb[b]) begin
          mem[cmd.addr][b*8 +: 8] <= cmd.wr_data[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_resp_valid <= 1'b0;
    end else if (rd_accept) begin
      o_resp_valid <= 1'b1;
    end else if (i_resp_ready) begin
      o_resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) begin
      o_resp_data <= mem[cmd.addr];
      o_resp_meta <= cmd.meta;
    end
  end

endmodule

//--- sim/axi_sram_tb.sv
`include "axi_sram_params.svh"

module axi_sram_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import axi_types_pkg::*;
  import sram_types_pkg::*;

  localparam int WAIT_LIMIT = 400;
  localparam int CH_AW = 0;
  localparam int CH_W  = 1;
  localparam int CH_B  = 2;
  localparam int CH_AR = 3;
  localparam int CH_R  = 4;

  logic       clk;
  logic       rst_n;
  logic       awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic       arvalid, arready, rvalid, rready, rlast;
  axi_id_t    awid, bid, arid, rid;
  axi_addr_t  awaddr, araddr;
  axi_len_t   awlen, arlen;
  logic [2:0] awsize, arsize;
  logic [1:0] awburst, arburst;
  axi_resp_t  bresp, rresp;
  sram_data_t wdata, rdata;
  sram_strb_t wstrb;

  // Reference copy of the SRAM contents
  sram_data_t shadow [`SRAM_DEPTH];
  int         errors = 0;
  int         timeouts = 0;
  int         bursts = 0;

  axi_sram_top i_axi_sram_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_awvalid(awvalid),
    .o_awready(awready),
    .i_awid   (awid),
    .i_awaddr (awaddr),
    .i_awlen  (awlen),
    .i_awsize (awsize),
    .i_awburst(awburst),
    .i_wvalid (wvalid),
    .o_wready (wready),
    .i_wdata  (wdata),
    .i_wstrb  (wstrb),
    .i_wlast  (wlast),
    .o_bvalid (bvalid),
    .i_bready (bready),
    .o_bid    (bid),
    .o_bresp  (bresp),
    .i_arvalid(arvalid),
    .o_arready(arready),
    .i_arid   (arid),
    .i_araddr (araddr),
    .i_arlen  (arlen),
    .i_arsize (arsize),
    .i_arburst(arburst),
    .o_rvalid (rvalid),
    .i_rready (rready),
    .o_rid    (rid),
    .o_rdata  (rdata),
    .o_rresp  (rresp),
    .o_rlast  (rlast)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Response back-pressure about one cycle in three
  initial begin : ready_gen
    void'($urandom(49));
    bready <= 1'b1;
    rready <= 1'b1;
    forever begin
      @(posedge clk);
      bready <= ($urandom % 3) != 0;
      rready <= ($urandom % 3) != 0;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Returns at the falling edge before the transfer edge
  task automatic wait_for_handshake(input int chan, input string what, output bit ok);
    int cycles;
    bit seen;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      case (chan)
        CH_AW:   seen = awready;
        CH_W:    seen = wready;
        CH_B:    seen = bvalid && bready;
        CH_AR:   seen = arready;
        default: seen = rvalid && rready;
      endcase
      cycles++;
    end
    ok = seen;
    if (!seen) begin
      $display("Timeout: no %s within %0d cycles at %0t ns", what, WAIT_LIMIT, $time);
      timeouts++;
    end
  endtask

  task automatic write_burst(input axi_id_t id, input axi_addr_t addr, input int len,
                             input sram_data_t base, input sram_strb_t strb);
    bit         ok;
    int         k;
    int         word;
    sram_data_t data;
    @(posedge clk);
    awvalid <= 1'b1;
    awid    <= id;
    awaddr  <= addr;
    awlen   <= axi_len_t'(len);
    awsize  <= 3'd1;
    awburst <= 2'b01;
    wait_for_handshake(CH_AW, "awready", ok);
    @(posedge clk);
    awvalid <= 1'b0;
    for (k = 0; k <= len && ok; k++) begin
      data = sram_data_t'(base + k);
      wvalid <= 1'b1;
      wdata  <= data;
      wstrb  <= strb;
      wlast  <= (k == len);
      wait_for_handshake(CH_W, "wready", ok);
      if (ok) begin
        word = ((addr >> `BYTE_LSB) + k) % `SRAM_DEPTH;
        for (int b = 0; b < `STRB_W; b++) begin
          if (strb[b]) begin
            shadow[word][b*8 +: 8] = data[b*8 +: 8];
          end
        end
      end
      @(posedge clk);
    end
    wvalid <= 1'b0;
    wlast  <= 1'b0;
    if (ok) begin
      wait_for_handshake(CH_B, "bvalid", ok);
      if (ok) begin
        check_value($sformatf("bid of write id %0h", id), bid, id);
        check_value($sformatf("bresp of write id %0h", id), bresp, 0);
      end
    end
  endtask

  task automatic read_burst(input axi_id_t id, input axi_addr_t addr, input int len);
    bit ok;
    int k;
    int word;
    @(posedge clk);
    arvalid <= 1'b1;
    arid    <= id;
    araddr  <= addr;
    arlen   <= axi_len_t'(len);
    arsize  <= 3'd1;
    arburst <= 2'b01;
    wait_for_handshake(CH_AR, "arready", ok);
    @(posedge clk);
    arvalid <= 1'b0;
    for (k = 0; k <= len && ok; k++) begin
      wait_for_handshake(CH_R, "rvalid", ok);
      if (ok) begin
        word = ((addr >> `BYTE_LSB) + k) % `SRAM_DEPTH;
        check_value($sformatf("rdata id %0h beat %0d", id, k), rdata, shadow[word]);
        check_value($sformatf("rid id %0h beat %0d", id, k), rid, id);
        check_value($sformatf("rresp id %0h beat %0d", id, k), rresp, 0);
        check_value($sformatf("rlast id %0h beat %0d", id, k), rlast, k == len);
      end
    end
  endtask

  initial begin
    int          fd;
    int          n;
    int          len;
    string       line;
    logic [7:0]  op;
    axi_id_t     id;
    axi_addr_t   addr;
    axi_addr_t   raddr;
    sram_data_t  base;
    sram_strb_t  strb;
    rst_n   <= 1'b0;
    awvalid <= 1'b0;
    awid    <= '0;
    awaddr  <= '0;
    awlen   <= '0;
    awsize  <= 3'd1;
    awburst <= 2'b01;
    wvalid  <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wlast   <= 1'b0;
    arvalid <= 1'b0;
    arid    <= '0;
    araddr  <= '0;
    arlen   <= '0;
    arsize  <= 3'd1;
    arburst <= 2'b01;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // Idle state straight after reset
    @(negedge clk);
    check_value("bvalid after reset", bvalid, 0);
    check_value("rvalid after reset", rvalid, 0);
    check_value("awready after reset", awready, 1);
    check_value("arready after reset", arready, 1);

    fd = $fopen("sim/axi_sram_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file sim/axi_sram_tests.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%c %h %h %d %h %h %h", op, id, addr, len, base, strb, raddr);
          if (n != 7) begin
            $display("Malformed line in the test file: %s", line);
            errors++;
          end else begin
            bursts++;
            case (op)
              "W": write_burst(id, addr, len, base, strb);
              "R": read_burst(id, addr, len);
              "B": begin
                fork
                  write_burst(id, addr, len, base, strb);
                  read_burst(id, raddr, len);
                join
              end
              default: begin
                $display("Unknown operation %c in the test file", op);
                errors++;
              end
            endcase
          end
        end
      end
      $fclose(fd);
    end

    repeat (5) @(posedge clk);
    $display("Bursts run: %0d, errors: %0d, timeouts: %0d", bursts, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- sim/axi_sram_tests.txt
# op id addr len base strb raddr; op W write, R read, B write and read together
# id, addr, base, strb and raddr in hex; len in decimal, beats minus one; raddr used by B only
W 1 00100 0 a5c3 3 00000
R 2 00100 0 0000 0 00000
W 3 00200 7 1000 3 00000
R 4 00200 7 0000 0 00000
W 5 00300 3 2000 3 00000
W 6 00302 1 ff00 1 00000
R 7 00300 3 0000 0 00000
W 8 00304 0 ee11 2 00000
R 9 00300 3 0000 0 00000
W a 00400 15 4000 3 00000
R b 00400 15 0000 0 00000
B c 00500 7 5000 3 00200
R d 00500 7 0000 0 00000
B e 00600 3 6000 3 00400
R f 00600 3 0000 0 00000
B 3 00700 5 7700 3 00500
R 4 00700 5 0000 0 00000
W 0 ffffe 1 7000 3 00000
R 1 ffffe 1 0000 0 00000
R 2 007fe 1 0000 0 00000

//--- sram_bridge/axi_rd_path.sv
`include "axi_sram_params.svh"

module axi_rd_path (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       i_arvalid,
  output logic                       o_arready,
  input  axi_types_pkg::axi_id_t     i_arid,
  input  axi_types_pkg::axi_addr_t   i_araddr,
  input  axi_types_pkg::axi_len_t    i_arlen,
  input  logic [2:0]                 i_arsize,
  input  logic [1:0]                 i_arburst,
  output logic                       o_rvalid,
  input  logic                       i_rready,
  output axi_types_pkg::axi_id_t     o_rid,
  output sram_types_pkg::sram_data_t o_rdata,
  output axi_types_pkg::axi_resp_t   o_rresp,
  output logic                       o_rlast,
  sram_cmd_if.requester              rd_req,
  input  logic                       i_resp_valid,
  output logic                       o_resp_ready,
  input  sram_types_pkg::sram_data_t i_resp_data,
  input  sram_types_pkg::sram_meta_t i_resp_meta
);
  import axi_types_pkg::*;
  import sram_types_pkg::*;

  axi_id_t    rid_q;
  sram_addr_t beat_addr;
  logic       beat_last;
  logic       burst_busy;
  logic       ar_fire;
  logic       last_beat_out;

  // Size and burst type are not needed, every burst is treated as INCR
  assign ar_fire = i_arvalid && o_arready;

  burst_counter i_burst_counter (
    .clk   (clk),
    .rst_n (rst_n),
    .i_load(ar_fire),
    .i_addr(i_araddr[`BYTE_LSB +: `SRAM_ADDR_W]),
    .i_len (i_arlen),
    .i_step(rd_req.valid && rd_req.ready),
    .o_addr(beat_addr),
    .o_last(beat_last),
    .o_busy(burst_busy)
  );

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rid_q <= i_arid;
    end
  end

  // Each read carries its ID and last flag through the SRAM
  assign rd_req.valid   = burst_busy;
  assign rd_req.wr_en   = 1'b0;
  assign rd_req.addr    = beat_addr;
  assign rd_req.meta    = {rid_q, beat_last};
  assign rd_req.wr_data = '0;
  assign rd_req.wr_strb = '0;

  // R channel is the SRAM response register
  assign o_rvalid     = i_resp_valid;
  assign o_rdata      = i_resp_data;
  assign o_rid        = i_resp_meta[`AXI_ID_W:1];
  assign o_rlast      = i_resp_meta[0];
  assign o_rresp      = AXI_RESP_OKAY;
  assign o_resp_ready = i_rready;

  assign last_beat_out = i_resp_valid && i_rready && i_resp_meta[0];

  // Next AR only once the tagged last beat has left
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_arready <= 1'b1;
    end else if (ar_fire) begin
      o_arready <= 1'b0;
    end else if (last_beat_out) begin
      o_arready <= 1'b1;
    end
  end

endmodule

//--- sram_bridge/axi_wr_path.sv
`include "axi_sram_params.svh"

module axi_wr_path (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       i_awvalid,
  output logic                       o_awready,
  input  axi_types_pkg::axi_id_t     i_awid,
  input  axi_types_pkg::axi_addr_t   i_awaddr,
  input  axi_types_pkg::axi_len_t    i_awlen,
  input  logic [2:0]                 i_awsize,
  input  logic [1:0]                 i_awburst,
  input  logic                       i_wvalid,
  output logic                       o_wready,
  input  sram_types_pkg::sram_data_t i_wdata,
  input  sram_types_pkg::sram_strb_t i_wstrb,
  input  logic                       i_wlast,
  output logic                       o_bvalid,
  input  logic                       i_bready,
  output axi_types_pkg::axi_id_t     o_bid,
  output axi_types_pkg::axi_resp_t   o_bresp,
  sram_cmd_if.requester              wr_req
);
  import axi_types_pkg::*;
  import sram_types_pkg::*;

  axi_id_t    bid_q;
  sram_addr_t beat_addr;
  logic       beat_last;
  logic       burst_busy;
  logic       aw_fire;
  logic       beat_done;

  // Size, burst type and wlast add nothing for full-width INCR bursts,
  // the beat count comes from awlen
  assign aw_fire   = i_awvalid && o_awready;
  assign beat_done = wr_req.valid && wr_req.ready;

  burst_counter i_burst_counter (
    .clk   (clk),
    .rst_n (rst_n),
    .i_load(aw_fire),
    .i_addr(i_awaddr[`BYTE_LSB +: `SRAM_ADDR_W]),
    .i_len (i_awlen),
    .i_step(beat_done),
    .o_addr(beat_addr),
    .o_last(beat_last),
    .o_busy(burst_busy)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_awready <= 1'b1;
      o_bvalid  <= 1'b0;
    end else begin
      if (aw_fire) begin
        o_awready <= 1'b0;
      end else if (o_bvalid && i_bready) begin
        o_awready <= 1'b1;
      end
      if (beat_done && beat_last) begin
        o_bvalid <= 1'b1;
      end else if (i_bready) begin
        o_bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      bid_q <= i_awid;
    end
  end

  // W beats go straight out as SRAM writes
  assign wr_req.valid   = burst_busy && i_wvalid;
  assign wr_req.wr_en   = 1'b1;
  assign wr_req.addr    = beat_addr;
  assign wr_req.meta    = '0;
  assign wr_req.wr_data = i_wdata;
  assign wr_req.wr_strb = i_wstrb;
  assign o_wready       = burst_busy && wr_req.ready;

  assign o_bid   = bid_q;
  assign o_bresp = AXI_RESP_OKAY;

endmodule

//--- sram_bridge/burst_counter.sv
module burst_counter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       i_load,
  input  sram_types_pkg::sram_addr_t i_addr,
  input  axi_types_pkg::axi_len_t    i_len,
  input  logic                       i_step,
  output sram_types_pkg::sram_addr_t o_addr,
  output logic                       o_last,
  output logic                       o_busy
);
  import axi_types_pkg::*;
  import sram_types_pkg::*;

  sram_addr_t addr_q;
  axi_len_t   remain_q;
  logic       busy_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q   <= 1'b0;
      remain_q <= '0;
    end else if (i_load) begin
      busy_q   <= 1'b1;
      remain_q <= i_len;
    end else if (i_step && busy_q) begin
      remain_q <= remain_q - 1'b1;
      if (remain_q == '0) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Word address wraps at the SRAM depth
  always_ff @(posedge clk) begin
    if (i_load) begin
      addr_q <= i_addr;
    end else if (i_step && busy_q) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  assign o_addr = addr_q;
  assign o_last = busy_q && (remain_q == '0);
  assign o_busy = busy_q;

endmodule

//--- sram_bridge/sram_arbiter.sv
module sram_arbiter (
  input  logic          clk,
  input  logic          rst_n,
  sram_cmd_if.server    wr_req,
  sram_cmd_if.server    rd_req,
  sram_cmd_if.requester mem_cmd,
  input  logic          i_rready,
  input  logic          i_bready
);
  import sram_types_pkg::*;

  arb_state_t state;
  arb_state_t state_next;
  arb_state_t fair_state;
  logic       pri_read;

  // Reads win right after an accepted write
  always_comb begin
    pri_read = 1'b0;
    if (state == ARB_WRITE) begin
      pri_read = wr_req.valid && mem_cmd.ready;
    end else if (state == ARB_WRITE_RESP) begin
      pri_read = i_bready;
    end
  end

  // Writes win at every other grant
  always_comb begin
    if (pri_read) begin
      fair_state = rd_req.valid ? ARB_READ : (wr_req.valid ? ARB_WRITE : ARB_IDLE);
    end else begin
      fair_state = wr_req.valid ? ARB_WRITE : (rd_req.valid ? ARB_READ : ARB_IDLE);
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ARB_IDLE: state_next = fair_state;
      ARB_READ: begin
        if (!rd_req.valid) begin
          state_next = fair_state;
        end else if (mem_cmd.ready) begin
          state_next = i_rready ? fair_state : ARB_READ_RESP;
        end
      end
      ARB_READ_RESP: begin
        if (i_rready) begin
          state_next = fair_state;
        end
      end
      ARB_WRITE: begin
        if (!wr_req.valid) begin
          state_next = fair_state;
        end else if (mem_cmd.ready) begin
          state_next = i_bready ? fair_state : ARB_WRITE_RESP;
        end
      end
      ARB_WRITE_RESP: begin
        if (i_bready) begin
          state_next = fair_state;
        end
      end
      default: state_next = ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ARB_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Only the granted side sees the SRAM
  always_comb begin
    mem_cmd.valid   = 1'b0;
    mem_cmd.wr_en   = 1'b0;
    mem_cmd.addr    = '0;
    mem_cmd.meta    = '0;
    mem_cmd.wr_data = '0;
    mem_cmd.wr_strb = '0;
    rd_req.ready    = 1'b0;
    wr_req.ready    = 1'b0;
    if (state == ARB_READ) begin
      mem_cmd.valid   = rd_req.valid;
      mem_cmd.wr_en   = rd_req.wr_en;
      mem_cmd.addr    = rd_req.addr;
      mem_cmd.meta    = rd_req.meta;
      mem_cmd.wr_data = rd_req.wr_data;
      mem_cmd.wr_strb = rd_req.wr_strb;
      rd_req.ready    = mem_cmd.ready;
    end else if (state == ARB_WRITE) begin
      mem_cmd.valid   = wr_req.valid;
      mem_cmd.wr_en   = wr_req.wr_en;
      mem_cmd.addr    = wr_req.addr;
      mem_cmd.meta    = wr_req.meta;
      mem_cmd.wr_data = wr_req.wr_data;
      mem_cmd.wr_strb = wr_req.wr_strb;
      wr_req.ready    = mem_cmd.ready;
    end
  end

endmodule
